/* run_sim.sh */
#!/bin/sh
# Build and run the query router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_db_query_router \
    -f verilog.f \
    -o sim_tb_db_query_router
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/sim_tb_db_query_router > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0

/* source/ctxt_fifo.sv */
`timescale 1ns/1ps

`include "db_params.svh"

module ctxt_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `DB_MAX_OPEN
) (
    input  logic clk,
    input  logic i_reset,
    input  logic i_push,
    input  T     i_push_data,
    input  logic i_pop,
    output T     o_head,
    output logic o_full,
    output logic o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                   mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    // Overflow and underflow are dropped, the assertions below report them
    assign wr_en = i_push && !o_full;
    assign rd_en = i_pop && !o_empty;

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);

    // Oldest open entry
    assign o_head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged when push and pop coincide
    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The stage above must hold off requests while full
    a_no_overflow : assert property (
        @(posedge clk) disable iff (i_reset) i_push |-> !o_full
    ) else $error("ctxt_fifo: push while full");

    // Every response must belong to an open query
    a_no_underflow : assert property (
        @(posedge clk) disable iff (i_reset) i_pop |-> !o_empty
    ) else $error("ctxt_fifo: pop while empty");

endmodule : ctxt_fifo

/* source/db_params.svh */
`ifndef DB_PARAMS_SVH
`define DB_PARAMS_SVH

// Lookup bus widths

// Width of a lookup key
`define DB_KEY_W 8

// Width of a returned value
`define DB_VALUE_W 32

// Lookup banks behind the router

// Number of banks served in round-robin order
`define DB_NUM_BANKS 2

// Queries open at once, also the depth of every context FIFO
`define DB_MAX_OPEN 8

// Width of a bank index, never below one bit
`define DB_BANK_SEL_W ((`DB_NUM_BANKS > 1) ? $clog2(`DB_NUM_BANKS) : 1)

`endif

/* source/db_pkg.sv */
`include "db_params.svh"

package db_pkg;

    // Lookup key as presented by a requester
    typedef logic [`DB_KEY_W-1:0] key_t;

    // Value returned with the ack
    typedef logic [`DB_VALUE_W-1:0] value_t;

    // Index of one lookup bank
    typedef logic [`DB_BANK_SEL_W-1:0] bank_sel_t;

    // Which requester issued a query
    typedef enum logic {
        SRC_HI = 1'b0,
        SRC_LO = 1'b1
    } req_src_e;

endpackage : db_pkg

/* source/db_prio_mux.sv */
`timescale 1ns/1ps

`include "db_params.svh"

module db_prio_mux
    import db_pkg::*;
(
    input  logic   clk,
    input  logic   i_reset,

    // High-priority requester
    input  logic   i_hi_req,
    input  key_t   i_hi_key,
    output logic   o_hi_rdy,
    output logic   o_hi_ack,
    output logic   o_hi_error,
    output logic   o_hi_valid,
    output value_t o_hi_value,

    // Low-priority requester
    input  logic   i_lo_req,
    input  key_t   i_lo_key,
    output logic   o_lo_rdy,
    output logic   o_lo_ack,
    output logic   o_lo_error,
    output logic   o_lo_valid,
    output value_t o_lo_value,

    // Toward the demux
    output logic   o_req,
    output key_t   o_key,
    input  logic   i_rdy,
    input  logic   i_ack,
    input  logic   i_error,
    input  logic   i_valid,
    input  value_t i_value
);

    req_src_e sel_src;
    req_src_e head_src;
    logic     accept;
    logic     fifo_full;
    logic     fifo_empty;
    logic     hi_resp;
    logic     lo_resp;

    // Strict priority, high side wins whenever it requests
    assign sel_src = i_hi_req ? SRC_HI : SRC_LO;

    // No new query is offered while the context store is full
    assign o_req = (i_hi_req || i_lo_req) && !fifo_full;
    assign o_key = i_hi_req ? i_hi_key : i_lo_key;

    // Low side is held off for as long as high side requests
    assign o_hi_rdy = i_rdy && !fifo_full;
    assign o_lo_rdy = i_rdy && !fifo_full && !i_hi_req;

    assign accept = o_req && i_rdy;

    // Source of every open query, oldest at the head
    ctxt_fifo #(
        .T       ( req_src_e ),
        .DEPTH   ( `DB_MAX_OPEN )
    ) u_src_fifo (
        .clk         ( clk ),
        .i_reset     ( i_reset ),
        .i_push      ( accept ),
        .i_push_data ( sel_src ),
        .i_pop       ( i_ack ),
        .o_head      ( head_src ),
        .o_full      ( fifo_full ),
        .o_empty     ( fifo_empty )
    );

    // Steer each response to whoever asked the oldest open query
    assign hi_resp = i_ack && !fifo_empty && (head_src == SRC_HI);
    assign lo_resp = i_ack && !fifo_empty && (head_src == SRC_LO);

    assign o_hi_ack   = hi_resp;
    assign o_hi_error = hi_resp && i_error;
    assign o_hi_valid = hi_resp && i_valid;
    assign o_hi_value = hi_resp ? i_value : '0;

    assign o_lo_ack   = lo_resp;
    assign o_lo_error = lo_resp && i_error;
    assign o_lo_valid = lo_resp && i_valid;
    assign o_lo_value = lo_resp ? i_value : '0;

endmodule : db_prio_mux

/* source/db_query_router.sv */
`timescale 1ns/1ps

`include "db_params.svh"

module db_query_router
    import db_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_reset,

    // High-priority requester
    input  logic                     i_hi_req,
    input  key_t                     i_hi_key,
    output logic                     o_hi_rdy,
    output logic                     o_hi_ack,
    output logic                     o_hi_error,
    output logic                     o_hi_valid,
    output value_t                   o_hi_value,

    // Low-priority requester
    input  logic                     i_lo_req,
    input  key_t                     i_lo_key,
    output logic                     o_lo_rdy,
    output logic                     o_lo_ack,
    output logic                     o_lo_error,
    output logic                     o_lo_valid,
    output value_t                   o_lo_value,

    // Lookup banks
    output logic [`DB_NUM_BANKS-1:0] o_bank_req,
    output key_t                     o_bank_key,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_rdy,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_ack,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_error,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_valid,
    input  value_t                   i_bank_value [`DB_NUM_BANKS]
);

    // Merged query stream between the two stages
    logic   mid_req;
    key_t   mid_key;
    logic   mid_rdy;
    logic   mid_ack;
    logic   mid_error;
    logic   mid_valid;
    value_t mid_value;

    db_prio_mux u_db_prio_mux (
        .clk        ( clk ),
        .i_reset    ( i_reset ),
        .i_hi_req   ( i_hi_req ),
        .i_hi_key   ( i_hi_key ),
        .o_hi_rdy   ( o_hi_rdy ),
        .o_hi_ack   ( o_hi_ack ),
        .o_hi_error ( o_hi_error ),
        .o_hi_valid ( o_hi_valid ),
        .o_hi_value ( o_hi_value ),
        .i_lo_req   ( i_lo_req ),
        .i_lo_key   ( i_lo_key ),
        .o_lo_rdy   ( o_lo_rdy ),
        .o_lo_ack   ( o_lo_ack ),
        .o_lo_error ( o_lo_error ),
        .o_lo_valid ( o_lo_valid ),
        .o_lo_value ( o_lo_value ),
        .o_req      ( mid_req ),
        .o_key      ( mid_key ),
        .i_rdy      ( mid_rdy ),
        .i_ack      ( mid_ack ),
        .i_error    ( mid_error ),
        .i_valid    ( mid_valid ),
        .i_value    ( mid_value )
    );

    db_rr_demux u_db_rr_demux (
        .clk          ( clk ),
        .i_reset      ( i_reset ),
        .i_req        ( mid_req ),
        .i_key        ( mid_key ),
        .o_rdy        ( mid_rdy ),
        .o_ack        ( mid_ack ),
        .o_error      ( mid_error ),
        .o_valid      ( mid_valid ),
        .o_value      ( mid_value ),
        .o_bank_req   ( o_bank_req ),
        .o_bank_key   ( o_bank_key ),
        .i_bank_rdy   ( i_bank_rdy ),
        .i_bank_ack   ( i_bank_ack ),
        .i_bank_error ( i_bank_error ),
        .i_bank_valid ( i_bank_valid ),
        .i_bank_value ( i_bank_value )
    );

endmodule : db_query_router

/* source/db_rr_demux.sv */
`timescale 1ns/1ps

`include "db_params.svh"

module db_rr_demux
    import db_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_reset,

    // From the priority mux
    input  logic                     i_req,
    input  key_t                     i_key,
    output logic                     o_rdy,
    output logic                     o_ack,
    output logic                     o_error,
    output logic                     o_valid,
    output value_t                   o_value,

    // Bank side
    output logic [`DB_NUM_BANKS-1:0] o_bank_req,
    output key_t                     o_bank_key,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_rdy,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_ack,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_error,
    input  logic [`DB_NUM_BANKS-1:0] i_bank_valid,
    input  value_t                   i_bank_value [`DB_NUM_BANKS]
);

    bank_sel_t rr_ptr;
    bank_sel_t head_bank;
    logic      accept;
    logic      fifo_full;
    logic      fifo_empty;

    // Only the bank under the pointer sees the request
    always_comb begin
        for (int i = 0; i < `DB_NUM_BANKS; i++) begin
            o_bank_req[i] = i_req && !fifo_full && (rr_ptr == bank_sel_t'(i));
        end
    end

    assign o_bank_key = i_key;
    assign o_rdy      = i_bank_rdy[rr_ptr] && !fifo_full;
    assign accept     = i_req && o_rdy;

    // Round-robin pointer, steps after each accepted query
    always_ff @(posedge clk) begin
        if (i_reset) begin
            rr_ptr <= '0;
        end else if (accept) begin
            if (rr_ptr == bank_sel_t'(`DB_NUM_BANKS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    // Bank of every open query in accept order
    ctxt_fifo #(
        .T       ( bank_sel_t ),
        .DEPTH   ( `DB_MAX_OPEN )
    ) u_bank_fifo (
        .clk         ( clk ),
        .i_reset     ( i_reset ),
        .i_push      ( accept ),
        .i_push_data ( rr_ptr ),
        .i_pop       ( o_ack ),
        .o_head      ( head_bank ),
        .o_full      ( fifo_full ),
        .o_empty     ( fifo_empty )
    );

    // Response comes from the bank holding the oldest open query
    assign o_ack   = !fifo_empty && i_bank_ack[head_bank];
    assign o_error = o_ack && i_bank_error[head_bank];
    assign o_valid = o_ack && i_bank_valid[head_bank];
    assign o_value = o_ack ? i_bank_value[head_bank] : '0;

    // A bank must never answer when nothing is open
    a_ack_has_query : assert property (
        @(posedge clk) disable iff (i_reset) (|i_bank_ack) |-> !fifo_empty
    ) else $error("db_rr_demux: bank ack with no open query");

    // Banks answer in global accept order, so only the head bank may ack
    a_ack_in_order : assert property (
        @(posedge clk) disable iff (i_reset)
        ((|i_bank_ack) && !fifo_empty) |->
            (i_bank_ack == (`DB_NUM_BANKS'(1) << head_bank))
    ) else $error("db_rr_demux: bank ack out of order");

endmodule : db_rr_demux

/* verification/tb_db_query_router.sv */
`timescale 1ns/1ps

`include "db_params.svh"

module tb_db_query_router
    import db_pkg::*;
;

    localparam int TIMEOUT = 200;

    // One table row with the queries to issue, the bank stall, the burst length and expected banks
    typedef struct {
        bit   hi_en;
        key_t hi_key;
        bit   hi_bank;
        bit   lo_en;
        key_t lo_key;
        bit   lo_bank;
        int   stall;
        int   burst;
    } step_t;

    logic                     clk;
    logic                     i_reset;
    logic                     i_hi_req;
    key_t                     i_hi_key;
    logic                     o_hi_rdy;
    logic                     o_hi_ack;
    logic                     o_hi_error;
    logic                     o_hi_valid;
    value_t                   o_hi_value;
    logic                     i_lo_req;
    key_t                     i_lo_key;
    logic                     o_lo_rdy;
    logic                     o_lo_ack;
    logic                     o_lo_error;
    logic                     o_lo_valid;
    value_t                   o_lo_value;
    logic [`DB_NUM_BANKS-1:0] o_bank_req;
    key_t                     o_bank_key;
    logic [`DB_NUM_BANKS-1:0] i_bank_rdy;
    logic [`DB_NUM_BANKS-1:0] i_bank_ack;
    logic [`DB_NUM_BANKS-1:0] i_bank_error;
    logic [`DB_NUM_BANKS-1:0] i_bank_valid;
    value_t                   i_bank_value [`DB_NUM_BANKS];

    step_t      steps[$];
    // Entries are {bank, key}
    logic [8:0] exp_hi[$];
    logic [8:0] exp_lo[$];
    logic [8:0] open_q[$];
    int         value_errs;
    int         other_errs;
    bit         hold;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    db_query_router u_db_query_router (
        .clk          ( clk ),
        .i_reset      ( i_reset ),
        .i_hi_req     ( i_hi_req ),
        .i_hi_key     ( i_hi_key ),
        .o_hi_rdy     ( o_hi_rdy ),
        .o_hi_ack     ( o_hi_ack ),
        .o_hi_error   ( o_hi_error ),
        .o_hi_valid   ( o_hi_valid ),
        .o_hi_value   ( o_hi_value ),
        .i_lo_req     ( i_lo_req ),
        .i_lo_key     ( i_lo_key ),
        .o_lo_rdy     ( o_lo_rdy ),
        .o_lo_ack     ( o_lo_ack ),
        .o_lo_error   ( o_lo_error ),
        .o_lo_valid   ( o_lo_valid ),
        .o_lo_value   ( o_lo_value ),
        .o_bank_req   ( o_bank_req ),
        .o_bank_key   ( o_bank_key ),
        .i_bank_rdy   ( i_bank_rdy ),
        .i_bank_ack   ( i_bank_ack ),
        .i_bank_error ( i_bank_error ),
        .i_bank_valid ( i_bank_valid ),
        .i_bank_value ( i_bank_value )
    );

    // Bank index goes in the top byte and the key in the low byte
    function automatic value_t rule_value(bit bank, key_t key);
        return {7'h0, bank, 16'h0, key};
    endfunction

    // Bank model that answers the shared queue in accept order after a random delay
    initial begin
        logic [8:0] head;
        int         delay;
        void'($urandom(32'h05ac440a));
        delay        = 0;
        i_bank_ack   = '0;
        i_bank_error = '0;
        i_bank_valid = '0;
        for (int b = 0; b < `DB_NUM_BANKS; b++) begin
            i_bank_value[b] = '0;
        end
        forever begin
            @(negedge clk);
            i_bank_ack   = '0;
            i_bank_error = '0;
            i_bank_valid = '0;
            if (!hold && !i_reset && open_q.size() > 0) begin
                if (delay > 0) begin
                    delay--;
                end else begin
                    head = open_q.pop_front();
                    i_bank_ack[head[8]]   = 1'b1;
                    i_bank_valid[head[8]] = (head[7:0] != 8'h00);
                    i_bank_error[head[8]] = (head[7:0] == 8'hFF);
                    i_bank_value[head[8]] = rule_value(head[8], head[7:0]);
                    delay = $urandom % 5;
                end
            end
        end
    end

    task automatic check_response(bit is_hi, logic valid, logic error, value_t value);
        logic [8:0] e;
        value_t     ev;
        int         pending;
        pending = is_hi ? exp_hi.size() : exp_lo.size();
        assert (pending > 0) else begin
            other_errs++;
            $display("Ack on the %s port with no query open from that requester",
                     is_hi ? "high-priority" : "low-priority");
        end
        if (pending > 0) begin
            e  = is_hi ? exp_hi.pop_front() : exp_lo.pop_front();
            ev = rule_value(e[8], e[7:0]);
            assert (value == ev) else begin
                value_errs++;
                $display("[FAIL] %0t: %s value %h, expected %h", $time,
                         is_hi ? "hi" : "lo", value, ev);
            end
            assert (valid == (e[7:0] != 8'h00)) else begin
                value_errs++;
                $display("[FAIL] %0t: valid %b for key %h", $time, valid, e[7:0]);
            end
            assert (error == (e[7:0] == 8'hFF)) else begin
                value_errs++;
                $display("[FAIL] %0t: error %b for key %h", $time, error, e[7:0]);
            end
        end
    endtask

    // Logs accepted queries for the bank model and checks every response
    always @(posedge clk) begin
        if (!i_reset) begin
            for (int b = 0; b < `DB_NUM_BANKS; b++) begin
                if (o_bank_req[b] && i_bank_rdy[b]) begin
                    open_q.push_back({1'(b), o_bank_key});
                end
            end
            assert (!(o_hi_ack && o_lo_ack)) else begin
                other_errs++;
                $display("Both requesters received an ack in the same cycle");
            end
            // Response outputs of a port stay low while it gets no ack
            assert (o_hi_ack || (!o_hi_error && !o_hi_valid && o_hi_value == '0)) else begin
                value_errs++;
                $display("[FAIL] %0t: hi response outputs active without an ack", $time);
            end
            assert (o_lo_ack || (!o_lo_error && !o_lo_valid && o_lo_value == '0)) else begin
                value_errs++;
                $display("[FAIL] %0t: lo response outputs active without an ack", $time);
            end
            if (o_hi_ack) begin
                check_response(1'b1, o_hi_valid, o_hi_error, o_hi_value);
            end
            if (o_lo_ack) begin
                check_response(1'b0, o_lo_valid, o_lo_error, o_lo_value);
            end
        end
    end

    // Raises the requests and waits until each is accepted
    task automatic issue_pair(bit hi_en, key_t hi_key, bit lo_en, key_t lo_key);
        int cycles;
        bit hi_left;
        bit lo_left;
        hi_left = hi_en;
        lo_left = lo_en;
        cycles  = 0;
        @(negedge clk);
        i_bank_rdy = '1;
        i_hi_req   = hi_en;
        i_hi_key   = hi_key;
        i_lo_req   = lo_en;
        i_lo_key   = lo_key;
        while ((hi_left || lo_left) && cycles < TIMEOUT) begin
            @(posedge clk);
            if (lo_left && o_lo_rdy) begin
                assert (!hi_left) else begin
                    other_errs++;
                    $display("Low-priority query accepted ahead of a waiting high one");
                end
                lo_left = 1'b0;
            end
            if (hi_left && o_hi_rdy) begin
                hi_left = 1'b0;
            end
            cycles++;
            @(negedge clk);
            if (!hi_left) begin
                i_hi_req = 1'b0;
            end
            if (!lo_left) begin
                i_lo_req = 1'b0;
            end
        end
        if (hi_left || lo_left) begin
            other_errs++;
            $display("Timeout: a query was never accepted");
            i_hi_req = 1'b0;
            i_lo_req = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_hi.size() > 0 || exp_lo.size() > 0) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_hi.size() > 0 || exp_lo.size() > 0) begin
            other_errs++;
            $display("Timeout: responses still missing after %0d cycles", TIMEOUT);
            exp_hi.delete();
            exp_lo.delete();
        end
    endtask

    task automatic apply_step(step_t s);
        key_t k;
        if (s.burst > 0) begin
            // Answers held back so that the context FIFOs fill up
            hold = 1'b1;
            for (int i = 0; i < s.burst; i++) begin
                k = s.lo_key + key_t'(i);
                exp_lo.push_back({s.lo_bank ^ 1'(i), k});
                if (i == s.burst - 1) begin
                    @(negedge clk);
                    i_lo_req = 1'b1;
                    i_lo_key = k;
                    repeat (2) begin
                        @(posedge clk);
                        assert (!o_lo_rdy) else begin
                            other_errs++;
                            $display("rdy stayed high with all open query slots in use");
                        end
                    end
                    hold = 1'b0;
                end
                issue_pair(1'b0, '0, 1'b1, k);
            end
        end else begin
            if (s.hi_en) begin
                exp_hi.push_back({s.hi_bank, s.hi_key});
            end
            if (s.lo_en) begin
                exp_lo.push_back({s.lo_bank, s.lo_key});
            end
            if (s.stall > 0) begin
                @(negedge clk);
                i_bank_rdy = '0;
                i_hi_req   = s.hi_en;
                i_hi_key   = s.hi_key;
                i_lo_req   = s.lo_en;
                i_lo_key   = s.lo_key;
                repeat (s.stall) begin
                    @(posedge clk);
                    assert (!o_hi_rdy && !o_lo_rdy) else begin
                        other_errs++;
                        $display("Query accepted while the banks held rdy low");
                    end
                end
            end
            issue_pair(s.hi_en, s.hi_key, s.lo_en, s.lo_key);
        end
        wait_drain();
    endtask

    task automatic add_step(bit he, key_t hk, bit hb, bit le, key_t lk, bit lb,
                            int stall, int burst);
        step_t s;
        s = '{he, hk, hb, le, lk, lb, stall, burst};
        steps.push_back(s);
    endtask

    initial begin
        value_errs = 0;
        other_errs = 0;
        hold       = 1'b0;
        i_reset    = 1'b1;
        i_hi_req   = 1'b0;
        i_hi_key   = '0;
        i_lo_req   = 1'b0;
        i_lo_key   = '0;
        i_bank_rdy = '1;
        // hi_en hi_key bank, lo_en lo_key bank, stall cycles, burst length
        add_step(0, 8'h00, 0, 1, 8'h11, 0, 0, 0);
        add_step(1, 8'h22, 1, 0, 8'h00, 0, 0, 0);
        add_step(0, 8'h00, 0, 1, 8'h33, 0, 0, 0);
        add_step(1, 8'h44, 1, 1, 8'h55, 0, 0, 0);
        add_step(1, 8'h66, 1, 0, 8'h00, 0, 3, 0);
        add_step(1, 8'hFF, 0, 0, 8'h00, 0, 0, 0);
        add_step(0, 8'h00, 0, 1, 8'h00, 1, 0, 0);
        add_step(0, 8'h00, 0, 1, 8'h80, 0, 0, `DB_MAX_OPEN + 1);
        add_step(1, 8'h01, 1, 1, 8'hFF, 0, 0, 0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d wrong values, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_db_query_router

/* verilog.f */
+incdir+source
source/db_pkg.sv
source/ctxt_fifo.sv
source/db_prio_mux.sv
source/db_rr_demux.sv
source/db_query_router.sv
verification/tb_db_query_router.sv
